// ==== compile.f ====
verilog/x86_decode_pkg.sv
verilog/decode_stage_if.sv
verilog/prefix_scanner.sv
verilog/opcode_form_lookup.sv
verilog/decode_opnd_signals.sv
verilog/insn_length_calc.sv
verilog/insn_decode_top.sv
tests/insn_decode_properties.sv
tests/tb_insn_decode.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := tb_insn_decode
FILELIST   := compile.f
BUILD_DIR  := obj_dir
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert -j 0
PASS_TEXT  := TEST PASSED

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

// ==== tests/tb_insn_decode.sv ====
module tb_insn_decode;

  localparam int clk_period      = 40;
  // Handshake inputs settle a quarter period after the falling edge
  localparam int sample_delay    = clk_period / 4;
  localparam int directed_count  = 18;
  localparam int stream_count    = 40;
  localparam int wait_limit      = 20;
  // 200 clock periods per queued instruction plus a margin of 100
  localparam int watchdog_cycles = (directed_count + stream_count) * 200 + 100;

  logic clk;
  logic reset;
  logic in_valid;
  logic in_ready;
  logic [x86_decode_pkg::window_bits-1:0] in_window;
  logic out_valid;
  logic out_ready;
  x86_decode_pkg::decoded_insn_t out_insn;

  int error_count;
  int check_count;
  int test_count;
  // Directed windows and expected results kept for the stream test
  logic [x86_decode_pkg::window_bits-1:0] case_window[$];
  x86_decode_pkg::decoded_insn_t          case_expect[$];

  insn_decode_top i_dut (
    .clk       (clk),
    .reset     (reset),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .in_window (in_window),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_insn  (out_insn)
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  initial begin
    #(watchdog_cycles * clk_period);
    $display("Watchdog ran out at %0t before the tests completed", $time);
    $display("TEST FAILED");
    $finish;
  end

  // First byte of seq lands in window byte 0 and the rest pads with 00
  function automatic logic [x86_decode_pkg::window_bits-1:0] pack_window(
    input logic [x86_decode_pkg::window_bits-1:0] seq,
    input int                                     n
  );
    logic [x86_decode_pkg::window_bits-1:0] w;
    w = '0;
    for (int i = 0; i < n; i++) begin
      w[i*8 +: 8] = seq[(n-1-i)*8 +: 8];
    end
    return w;
  endfunction

  // Flags in has run modrm, sib, disp, imm
  function automatic x86_decode_pkg::decoded_insn_t build_insn(
    input logic [3:0]                 length,
    input x86_decode_pkg::opnd_form_t form,
    input logic [3:0]                 has,
    input logic [7:0]                 modrm,
    input logic [7:0]                 sib,
    input logic [31:0]                disp,
    input logic [31:0]                imm,
    input logic                       opsize16,
    input logic                       addr16
  );
    x86_decode_pkg::decoded_insn_t insn;
    insn           = '0;
    insn.length    = length;
    insn.opnd_form = form;
    {insn.has_modrm, insn.has_sib, insn.has_disp, insn.has_imm} = has;
    insn.modrm     = modrm;
    insn.sib       = sib;
    insn.disp      = disp;
    insn.imm       = imm;
    insn.opsize16  = opsize16;
    insn.addr16    = addr16;
    return insn;
  endfunction

  task automatic compare_field(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("CHECK FAILED at %0t: %s expected %0h, got %0h", $time, name, expected, actual);
    end
  endtask

  task automatic check_insn(input x86_decode_pkg::decoded_insn_t expected,
                            input x86_decode_pkg::decoded_insn_t actual);
    compare_field("invalid", {31'd0, expected.invalid}, {31'd0, actual.invalid});
    compare_field("opnd_form", {28'd0, expected.opnd_form}, {28'd0, actual.opnd_form});
    compare_field("has_modrm", {31'd0, expected.has_modrm}, {31'd0, actual.has_modrm});
    compare_field("has_sib", {31'd0, expected.has_sib}, {31'd0, actual.has_sib});
    compare_field("has_disp", {31'd0, expected.has_disp}, {31'd0, actual.has_disp});
    compare_field("has_imm", {31'd0, expected.has_imm}, {31'd0, actual.has_imm});
    // ModR/M and SIB bytes only mean something when present
    if (expected.has_modrm) begin
      compare_field("modrm", {24'd0, expected.modrm}, {24'd0, actual.modrm});
    end
    if (expected.has_sib) begin
      compare_field("sib", {24'd0, expected.sib}, {24'd0, actual.sib});
    end
    compare_field("disp", expected.disp, actual.disp);
    compare_field("imm", expected.imm, actual.imm);
    compare_field("opsize16", {31'd0, expected.opsize16}, {31'd0, actual.opsize16});
    compare_field("addr16", {31'd0, expected.addr16}, {31'd0, actual.addr16});
  endtask

  task automatic check_length(input logic [3:0] expected, input logic [3:0] actual);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("CHECK FAILED at %0t: length expected %0d, got %0d", $time, expected, actual);
    end
  endtask

  // Called on a falling edge, returns on the falling edge after the DUT took the window
  task automatic send_window(input logic [x86_decode_pkg::window_bits-1:0] window);
    in_valid  = 1'b1;
    in_window = window;
    #(sample_delay);
    while (!in_ready) begin
      @(negedge clk);
      #(sample_delay);
    end
    @(negedge clk);
  endtask

  // One window through an idle pipeline with out_ready high
  task automatic run_case(input logic [x86_decode_pkg::window_bits-1:0] window,
                          input x86_decode_pkg::decoded_insn_t expected);
    int waited;
    case_window.push_back(window);
    case_expect.push_back(expected);
    @(negedge clk);
    send_window(window);
    in_valid = 1'b0;
    waited   = 0;
    while (!out_valid && waited < wait_limit) begin
      @(negedge clk);
      waited++;
    end
    if (out_valid) begin
      check_insn(expected, out_insn);
      check_length(expected.length, out_insn.length);
    end else begin
      error_count++;
      $display("No out_valid at %0t within %0d cycles of sending a window", $time, wait_limit);
    end
  endtask

  task automatic finish_test(input string name, input int errors_before);
    test_count++;
    $display("%s finished with %0d errors", name, error_count - errors_before);
  endtask

  task automatic modrm_register_and_disp8();
    int errors_before;
    errors_before = error_count;
    run_case(pack_window(120'h01C8, 2),
             build_insn(4'd2, x86_decode_pkg::opnd_enc_modregrm_rm_reg, 4'b1000,
                        8'hC8, 8'h00, 32'h0, 32'h0, 1'b0, 1'b0));
    run_case(pack_window(120'h8B45F8, 3),
             build_insn(4'd3, x86_decode_pkg::opnd_enc_modregrm_reg_rm, 4'b1010,
                        8'h45, 8'h00, 32'hFFFF_FFF8, 32'h0, 1'b0, 1'b0));
    finish_test("modrm_register_and_disp8", errors_before);
  endtask

  task automatic sib_addressing();
    int errors_before;
    errors_before = error_count;
    run_case(pack_window(120'h8B442408, 4),
             build_insn(4'd4, x86_decode_pkg::opnd_enc_modregrm_reg_rm, 4'b1110,
                        8'h44, 8'h24, 32'h8, 32'h0, 1'b0, 1'b0));
    // Base 100 under mod 00 has no displacement
    run_case(pack_window(120'h8B0424, 3),
             build_insn(4'd3, x86_decode_pkg::opnd_enc_modregrm_reg_rm, 4'b1100,
                        8'h04, 8'h24, 32'h0, 32'h0, 1'b0, 1'b0));
    // Base 101 with mod 00 means disp32
    run_case(pack_window(120'h8B042578563412, 7),
             build_insn(4'd7, x86_decode_pkg::opnd_enc_modregrm_reg_rm, 4'b1110,
                        8'h04, 8'h25, 32'h1234_5678, 32'h0, 1'b0, 1'b0));
    finish_test("sib_addressing", errors_before);
  endtask

  task automatic displacement_only();
    int errors_before;
    errors_before = error_count;
    run_case(pack_window(120'h8B0578563412, 6),
             build_insn(4'd6, x86_decode_pkg::opnd_enc_modregrm_reg_rm, 4'b1010,
                        8'h05, 8'h00, 32'h1234_5678, 32'h0, 1'b0, 1'b0));
    run_case(pack_window(120'hA178563412, 5),
             build_insn(4'd5, x86_decode_pkg::opnd_enc_disp, 4'b0010,
                        8'h00, 8'h00, 32'h1234_5678, 32'h0, 1'b0, 1'b0));
    // moffs16 under 67 is sign-extended
    run_case(pack_window(120'h67A13492, 4),
             build_insn(4'd4, x86_decode_pkg::opnd_enc_disp, 4'b0010,
                        8'h00, 8'h00, 32'hFFFF_9234, 32'h0, 1'b0, 1'b1));
    finish_test("displacement_only", errors_before);
  endtask

  task automatic prefixes_and_16bit();
    int errors_before;
    errors_before = error_count;
    run_case(pack_window(120'h66B83412, 4),
             build_insn(4'd4, x86_decode_pkg::opnd_enc_reg_imm, 4'b0001,
                        8'h00, 8'h00, 32'h0, 32'h1234, 1'b1, 1'b0));
    // rm 110 is no SIB in 16-bit mode
    run_case(pack_window(120'h678B46FC, 4),
             build_insn(4'd4, x86_decode_pkg::opnd_enc_modregrm_reg_rm, 4'b1010,
                        8'h46, 8'h00, 32'hFFFF_FFFC, 32'h0, 1'b0, 1'b1));
    run_case(pack_window(120'h678B060080, 5),
             build_insn(4'd5, x86_decode_pkg::opnd_enc_modregrm_reg_rm, 4'b1010,
                        8'h06, 8'h00, 32'hFFFF_8000, 32'h0, 1'b0, 1'b1));
    run_case(pack_window(120'h2E3E6605FF7F, 6),
             build_insn(4'd6, x86_decode_pkg::opnd_enc_eax_imm, 4'b0001,
                        8'h00, 8'h00, 32'h0, 32'h7FFF, 1'b1, 1'b0));
    // Four prefixes is the most the scanner strips
    run_case(pack_window(120'h26F3F06490, 5),
             build_insn(4'd5, x86_decode_pkg::opnd_enc_none, 4'b0000,
                        8'h00, 8'h00, 32'h0, 32'h0, 1'b0, 1'b0));
    finish_test("prefixes_and_16bit", errors_before);
  endtask

  task automatic immediates_and_invalid();
    int errors_before;
    x86_decode_pkg::decoded_insn_t bad;
    errors_before = error_count;
    run_case(pack_window(120'h83C07F, 3),
             build_insn(4'd3, x86_decode_pkg::opnd_enc_modregrm_rm_imm, 4'b1001,
                        8'hC0, 8'h00, 32'h0, 32'h7F, 1'b0, 1'b0));
    run_case(pack_window(120'h6A80, 2),
             build_insn(4'd2, x86_decode_pkg::opnd_enc_imm, 4'b0001,
                        8'h00, 8'h00, 32'h0, 32'hFFFF_FF80, 1'b0, 1'b0));
    run_case(pack_window(120'h69C078563412, 6),
             build_insn(4'd6, x86_decode_pkg::opnd_enc_modregrm_reg_rm_imm, 4'b1001,
                        8'hC0, 8'h00, 32'h0, 32'h1234_5678, 1'b0, 1'b0));
    run_case(pack_window(120'h0578563412, 5),
             build_insn(4'd5, x86_decode_pkg::opnd_enc_eax_imm, 4'b0001,
                        8'h00, 8'h00, 32'h0, 32'h1234_5678, 1'b0, 1'b0));
    // 0F escape is outside the one-byte map
    bad = build_insn(4'd1, x86_decode_pkg::opnd_enc_none, 4'b0000,
                     8'h00, 8'h00, 32'h0, 32'h0, 1'b0, 1'b0);
    bad.invalid = 1'b1;
    run_case(pack_window(120'h0F05, 2), bad);
    finish_test("immediates_and_invalid", errors_before);
  endtask

  task automatic stream_under_backpressure();
    int errors_before;
    int order[stream_count];
    int received;
    int idle;
    int extra;
    x86_decode_pkg::decoded_insn_t expected;
    errors_before = error_count;
    for (int k = 0; k < stream_count; k++) begin
      order[k] = $urandom_range(case_window.size() - 1);
    end
    received = 0;
    idle     = 0;
    fork
      begin
        @(negedge clk);
        for (int k = 0; k < stream_count; k++) begin
          send_window(case_window[order[k]]);
        end
        in_valid = 1'b0;
      end
      begin
        // Valid and ready both high at the fall means a transfer on the next rise
        while (received < stream_count && idle < wait_limit) begin
          @(negedge clk);
          out_ready = ($urandom_range(1) == 1);
          if (out_valid && out_ready) begin
            expected = case_expect[order[received]];
            check_insn(expected, out_insn);
            check_length(expected.length, out_insn.length);
            received++;
            idle = 0;
          end else if (!out_valid) begin
            idle++;
          end
        end
      end
    join
    if (received < stream_count) begin
      error_count++;
      $display("Stream stalled at %0t with %0d of %0d instructions out",
               $time, received, stream_count);
    end
    out_ready = 1'b1;
    extra     = 0;
    repeat (5) begin
      @(negedge clk);
      if (out_valid) begin
        extra++;
      end
    end
    if (extra != 0) begin
      error_count++;
      $display("Output kept coming after the last expected instruction at %0t", $time);
    end
    finish_test("stream_under_backpressure", errors_before);
  endtask

  initial begin
    void'($urandom(32'h1e27b4ac));
    error_count = 0;
    check_count = 0;
    test_count  = 0;
    reset       = 1'b1;
    in_valid    = 1'b0;
    in_window   = '0;
    out_ready   = 1'b1;
    repeat (3) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    modrm_register_and_disp8();
    sib_addressing();
    displacement_only();
    prefixes_and_16bit();
    immediates_and_invalid();
    stream_under_backpressure();
    $display("Ran %0d tests, %0d checks, %0d errors", test_count, check_count, error_count);
    if (error_count == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// ==== tests/insn_decode_properties.sv ====
module insn_decode_properties (
  input logic                          clk,
  input logic                          reset,
  input logic                          out_valid,
  input logic                          out_ready,
  input x86_decode_pkg::decoded_insn_t out_insn
);

  // Stalled output keeps valid high
  valid_held: assert property (@(posedge clk) disable iff (reset)
    out_valid && !out_ready |=> out_valid)
    else $error("out_valid fell while out_ready was low");

  // Payload frozen during a stall
  insn_stable: assert property (@(posedge clk) disable iff (reset)
    out_valid && !out_ready |=> $stable(out_insn))
    else $error("out_insn changed while stalled");

  // Every valid output is at least one byte long
  length_range: assert property (@(posedge clk) disable iff (reset)
    out_valid |-> out_insn.length != 4'd0)
    else $error("out_insn.length is zero on a valid output");

  sib_needs_modrm: assert property (@(posedge clk) disable iff (reset)
    out_valid && out_insn.has_sib |-> out_insn.has_modrm)
    else $error("has_sib set without has_modrm");

endmodule

bind insn_decode_top insn_decode_properties i_props (
  .clk       (clk),
  .reset     (reset),
  .out_valid (out_valid),
  .out_ready (out_ready),
  .out_insn  (out_insn)
);

// ==== verilog/insn_decode_top.sv ====
module insn_decode_top (
  input  logic                                   clk,
  input  logic                                   reset,
  input  logic                                   in_valid,
  output logic                                   in_ready,
  input  logic [x86_decode_pkg::window_bits-1:0] in_window,
  output logic                                   out_valid,
  input  logic                                   out_ready,
  output x86_decode_pkg::decoded_insn_t          out_insn
);

  // Prefix-stripped instruction between the two register stages
  decode_stage_if stage_bus ();

  // Stage 1 strips prefixes
  prefix_scanner i_prefix (
    .clk       (clk),
    .reset     (reset),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .in_window (in_window),
    .stage     (stage_bus.producer)
  );

  // Stage 2 decodes fields and length
  insn_length_calc i_length (
    .clk       (clk),
    .reset     (reset),
    .stage     (stage_bus.consumer),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_insn  (out_insn)
  );

endmodule

// ==== verilog/insn_length_calc.sv ====
module insn_length_calc (
  input  logic                          clk,
  input  logic                          reset,
  decode_stage_if.consumer              stage,
  output logic                          out_valid,
  input  logic                          out_ready,
  output x86_decode_pkg::decoded_insn_t out_insn
);

  x86_decode_pkg::opnd_form_t    opnd_form;
  x86_decode_pkg::imm_size_t     imm_size;
  x86_decode_pkg::decoded_insn_t next_insn;
  logic        invalid;
  logic        has_modrm;
  logic        has_sib;
  logic        has_disp;
  logic        has_imm;
  logic [7:0]  modrm;
  logic [7:0]  sib;
  logic [31:0] disp;
  logic [31:0] imm;
  logic [3:0]  field_bytes;

  opcode_form_lookup i_lookup (
    .opcode    (stage.body[7:0]),
    .opnd_form (opnd_form),
    .imm_size  (imm_size),
    .invalid   (invalid)
  );

  decode_opnd_signals i_opnd (
    .body        (stage.body),
    .opnd_form   (opnd_form),
    .imm_size    (imm_size),
    .opsize16    (stage.opsize16),
    .addr16      (stage.addr16),
    .has_modrm   (has_modrm),
    .has_sib     (has_sib),
    .has_disp    (has_disp),
    .has_imm     (has_imm),
    .modrm       (modrm),
    .sib         (sib),
    .disp        (disp),
    .imm         (imm),
    .field_bytes (field_bytes)
  );

  // Assemble the result, invalid opcodes count as one byte
  always_comb begin
    next_insn           = '0;
    next_insn.invalid   = invalid;
    next_insn.opnd_form = opnd_form;
    next_insn.opsize16  = stage.opsize16;
    next_insn.addr16    = stage.addr16;
    next_insn.length    = {1'b0, stage.prefix_count} + 4'd1;
    if (!invalid) begin
      next_insn.length    = {1'b0, stage.prefix_count} + 4'd1 + field_bytes;
      next_insn.has_modrm = has_modrm;
      next_insn.has_sib   = has_sib;
      next_insn.has_disp  = has_disp;
      next_insn.has_imm   = has_imm;
      next_insn.modrm     = modrm;
      next_insn.sib       = sib;
      next_insn.disp      = disp;
      next_insn.imm       = imm;
    end
  end

  // Output slot frees when empty or taken downstream
  assign stage.ready = !out_valid || out_ready;

  always_ff @(posedge clk) begin
    if (reset) begin
      out_valid <= 1'b0;
    end else if (stage.valid && stage.ready) begin
      out_valid <= 1'b1;
    end else if (out_ready) begin
      out_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (stage.valid && stage.ready) begin
      out_insn <= next_insn;
    end
  end

endmodule

// ==== verilog/decode_opnd_signals.sv ====
module decode_opnd_signals (
  input  logic [x86_decode_pkg::body_bits-1:0] body,
  input  x86_decode_pkg::opnd_form_t           opnd_form,
  input  x86_decode_pkg::imm_size_t            imm_size,
  input  logic                                 opsize16,
  input  logic                                 addr16,
  output logic                                 has_modrm,
  output logic                                 has_sib,
  output logic                                 has_disp,
  output logic                                 has_imm,
  output logic [7:0]                           modrm,
  output logic [7:0]                           sib,
  output logic [31:0]                          disp,
  output logic [31:0]                          imm,
  output logic [3:0]                           field_bytes
);

  logic [1:0] mod_field;
  logic [2:0] rm_field;
  logic       reg_direct;
  logic [3:0] modrm_bytes;
  logic [3:0] sib_bytes;
  logic [3:0] disp_bytes;
  logic [3:0] imm_bytes;
  logic [3:0] disp_pos;
  logic [3:0] imm_pos;
  logic [x86_decode_pkg::body_bits-1:0] disp_raw;
  logic [x86_decode_pkg::body_bits-1:0] imm_raw;

  // Sign-extend the low size bytes of a field
  function automatic logic [31:0] sext(input logic [31:0] raw, input logic [3:0] size);
    case (size)
      4'd1:    return {{24{raw[7]}}, raw[7:0]};
      4'd2:    return {{16{raw[15]}}, raw[15:0]};
      4'd4:    return raw;
      default: return 32'd0;
    endcase
  endfunction

  // ModR/M follows the opcode when the form carries one
  assign has_modrm = opnd_form inside {x86_decode_pkg::opnd_enc_modregrm_rm,
                                       x86_decode_pkg::opnd_enc_modregrm_rm_imm,
                                       x86_decode_pkg::opnd_enc_modregrm_reg_rm,
                                       x86_decode_pkg::opnd_enc_modregrm_rm_reg,
                                       x86_decode_pkg::opnd_enc_modregrm_reg_rm_imm};
  assign modrm      = body[15:8];
  assign mod_field  = modrm[7:6];
  assign rm_field   = modrm[2:0];
  assign reg_direct = (mod_field == 2'b11);

  // SIB only in 32-bit memory forms with rm 100
  assign has_sib = has_modrm && !addr16 && !reg_direct && (rm_field == 3'b100);
  assign sib     = body[23:16];

  always_comb begin
    disp_bytes = 4'd0;
    if (opnd_form == x86_decode_pkg::opnd_enc_disp) begin
      // moffs follows the address size
      disp_bytes = addr16 ? 4'd2 : 4'd4;
    end else if (has_modrm && !reg_direct) begin
      if (mod_field == 2'b01) begin
        disp_bytes = 4'd1;
      end else if (addr16) begin
        // 16-bit table, rm 110 under mod 00 is disp16 only
        if (mod_field == 2'b10 || rm_field == 3'b110) begin
          disp_bytes = 4'd2;
        end
      end else if (mod_field == 2'b10) begin
        disp_bytes = 4'd4;
      end else if (rm_field == 3'b101) begin
        disp_bytes = 4'd4;
      end else if (has_sib && sib[2:0] == 3'b101) begin
        // No base register, disp32 instead
        disp_bytes = 4'd4;
      end
    end
  end

  always_comb begin
    case (imm_size)
      x86_decode_pkg::imm_byte: imm_bytes = 4'd1;
      x86_decode_pkg::imm_full: imm_bytes = opsize16 ? 4'd2 : 4'd4;
      default:                  imm_bytes = 4'd0;
    endcase
  end

  assign modrm_bytes = {3'b000, has_modrm};
  assign sib_bytes   = {3'b000, has_sib};
  assign has_disp    = (disp_bytes != 4'd0);
  assign has_imm     = (imm_bytes != 4'd0);

  // Field order is opcode, ModR/M, SIB, disp, imm
  assign disp_pos    = 4'd1 + modrm_bytes + sib_bytes;
  assign imm_pos     = disp_pos + disp_bytes;
  assign field_bytes = modrm_bytes + sib_bytes + disp_bytes + imm_bytes;

  assign disp_raw = body >> {disp_pos, 3'b000};
  assign imm_raw  = body >> {imm_pos, 3'b000};
  assign disp     = sext(disp_raw[31:0], disp_bytes);
  assign imm      = sext(imm_raw[31:0], imm_bytes);

endmodule

// ==== verilog/opcode_form_lookup.sv ====
module opcode_form_lookup (
  input  logic [7:0]                opcode,
  output x86_decode_pkg::opnd_form_t opnd_form,
  output x86_decode_pkg::imm_size_t  imm_size,
  output logic                      invalid
);

  always_comb begin
    // Default is the unsupported case, 0F escape included
    opnd_form = x86_decode_pkg::opnd_enc_none;
    imm_size  = x86_decode_pkg::imm_none;
    invalid   = 1'b0;
    casez (opcode)
      // ADD/OR/SUB/MOV r/m, reg
      8'h01, 8'h09, 8'h29, 8'h89: opnd_form = x86_decode_pkg::opnd_enc_modregrm_rm_reg;
      // ADD/OR/SUB/MOV reg, r/m
      8'h03, 8'h0B, 8'h2B, 8'h8B: opnd_form = x86_decode_pkg::opnd_enc_modregrm_reg_rm;
      8'h81, 8'hC7: begin
        opnd_form = x86_decode_pkg::opnd_enc_modregrm_rm_imm;
        imm_size  = x86_decode_pkg::imm_full;
      end
      8'h83: begin
        opnd_form = x86_decode_pkg::opnd_enc_modregrm_rm_imm;
        imm_size  = x86_decode_pkg::imm_byte;
      end
      // Group 3 and group 5, no immediate
      8'hF7, 8'hFF: opnd_form = x86_decode_pkg::opnd_enc_modregrm_rm;
      x86_decode_pkg::opcode_imul_imm32: begin
        opnd_form = x86_decode_pkg::opnd_enc_modregrm_reg_rm_imm;
        imm_size  = x86_decode_pkg::imm_full;
      end
      x86_decode_pkg::opcode_imul_imm8: begin
        opnd_form = x86_decode_pkg::opnd_enc_modregrm_reg_rm_imm;
        imm_size  = x86_decode_pkg::imm_byte;
      end
      8'h05, 8'h2D: begin
        opnd_form = x86_decode_pkg::opnd_enc_eax_imm;
        imm_size  = x86_decode_pkg::imm_full;
      end
      // MOV reg, imm with register in the low bits
      8'b1011_1???: begin
        opnd_form = x86_decode_pkg::opnd_enc_reg_imm;
        imm_size  = x86_decode_pkg::imm_full;
      end
      // PUSH reg
      8'b0101_0???: opnd_form = x86_decode_pkg::opnd_enc_reg;
      x86_decode_pkg::opcode_push_imm32: begin
        opnd_form = x86_decode_pkg::opnd_enc_imm;
        imm_size  = x86_decode_pkg::imm_full;
      end
      x86_decode_pkg::opcode_push_imm8: begin
        opnd_form = x86_decode_pkg::opnd_enc_imm;
        imm_size  = x86_decode_pkg::imm_byte;
      end
      x86_decode_pkg::opcode_nop: opnd_form = x86_decode_pkg::opnd_enc_none;
      // moffs form, address only
      x86_decode_pkg::opcode_mov_eax_mem: opnd_form = x86_decode_pkg::opnd_enc_disp;
      default: invalid = 1'b1;
    endcase
  end

endmodule

// ==== verilog/prefix_scanner.sv ====
module prefix_scanner (
  input  logic                                   clk,
  input  logic                                   reset,
  input  logic                                   in_valid,
  output logic                                   in_ready,
  input  logic [x86_decode_pkg::window_bits-1:0] in_window,
  decode_stage_if.producer                       stage
);

  logic [2:0] prefix_count;
  logic       opsize16;
  logic       addr16;
  logic [x86_decode_pkg::window_bits-1:0] shifted;

  // Any of the eleven legacy prefix bytes
  function automatic logic is_prefix(input logic [7:0] b);
    return b inside {x86_decode_pkg::prefix_opsize, x86_decode_pkg::prefix_addrsize,
                     x86_decode_pkg::prefix_lock, x86_decode_pkg::prefix_rep,
                     x86_decode_pkg::prefix_repne, x86_decode_pkg::prefix_seg_es,
                     x86_decode_pkg::prefix_seg_cs, x86_decode_pkg::prefix_seg_ss,
                     x86_decode_pkg::prefix_seg_ds, x86_decode_pkg::prefix_seg_fs,
                     x86_decode_pkg::prefix_seg_gs};
  endfunction

  // Count the leading run of prefixes, stop at the first non-prefix
  always_comb begin
    logic       in_run;
    logic [7:0] b;
    in_run       = 1'b1;
    prefix_count = 3'd0;
    opsize16     = 1'b0;
    addr16       = 1'b0;
    for (int i = 0; i < x86_decode_pkg::max_prefixes; i++) begin
      b = in_window[i*8 +: 8];
      if (in_run && is_prefix(b)) begin
        prefix_count = prefix_count + 3'd1;
        if (b == x86_decode_pkg::prefix_opsize) begin
          opsize16 = 1'b1;
        end
        if (b == x86_decode_pkg::prefix_addrsize) begin
          addr16 = 1'b1;
        end
      end else begin
        in_run = 1'b0;
      end
    end
  end

  // Drop the prefix bytes so the opcode lands in byte 0
  assign shifted = in_window >> {prefix_count, 3'b000};

  // Register is free when empty or draining this cycle
  assign in_ready = !stage.valid || stage.ready;

  always_ff @(posedge clk) begin
    if (reset) begin
      stage.valid <= 1'b0;
    end else if (in_valid && in_ready) begin
      stage.valid <= 1'b1;
    end else if (stage.ready) begin
      stage.valid <= 1'b0;
    end
  end

  // Payload loads on acceptance only
  always_ff @(posedge clk) begin
    if (in_valid && in_ready) begin
      stage.body         <= shifted[x86_decode_pkg::body_bits-1:0];
      stage.prefix_count <= prefix_count;
      stage.opsize16     <= opsize16;
      stage.addr16       <= addr16;
    end
  end

endmodule

// ==== verilog/decode_stage_if.sv ====
interface decode_stage_if;

  // Stage handshake
  logic valid;
  logic ready;

  // Opcode sits in the lowest byte of body
  logic [x86_decode_pkg::body_bits-1:0] body;
  // Prefixes stripped ahead of body, 0 to 4
  logic [2:0] prefix_count;
  // Size overrides seen in the prefix run
  logic opsize16;
  logic addr16;

  modport producer (
    output valid, body, prefix_count, opsize16, addr16,
    input  ready
  );

  modport consumer (
    input  valid, body, prefix_count, opsize16, addr16,
    output ready
  );

endinterface

// ==== verilog/x86_decode_pkg.sv ====
package x86_decode_pkg;

  // Input window and post-prefix body sizes
  localparam int window_bytes = 15;
  localparam int window_bits  = window_bytes * 8;
  localparam int max_prefixes = 4;
  localparam int body_bytes   = window_bytes - max_prefixes;
  localparam int body_bits    = body_bytes * 8;

  // Operand encoding forms of the one-byte opcode map
  typedef enum logic [3:0] {
    opnd_enc_none                = 4'd0,
    opnd_enc_imm                 = 4'd1,
    opnd_enc_reg                 = 4'd2,
    opnd_enc_reg_imm             = 4'd3,
    opnd_enc_eax_imm             = 4'd4,
    opnd_enc_modregrm_rm         = 4'd5,
    opnd_enc_modregrm_rm_imm     = 4'd6,
    opnd_enc_modregrm_reg_rm     = 4'd7,
    opnd_enc_modregrm_rm_reg     = 4'd8,
    opnd_enc_modregrm_reg_rm_imm = 4'd9,
    opnd_enc_disp                = 4'd10
  } opnd_form_t;

  // Immediate size class, full means 4 bytes or 2 under 66
  typedef enum logic [1:0] {
    imm_none = 2'd0,
    imm_byte = 2'd1,
    imm_full = 2'd2
  } imm_size_t;

  // Legacy prefixes
  localparam logic [7:0] prefix_opsize   = 8'h66;
  localparam logic [7:0] prefix_addrsize = 8'h67;
  localparam logic [7:0] prefix_lock     = 8'hF0;
  localparam logic [7:0] prefix_rep      = 8'hF3;
  localparam logic [7:0] prefix_repne    = 8'hF2;
  localparam logic [7:0] prefix_seg_es   = 8'h26;
  localparam logic [7:0] prefix_seg_cs   = 8'h2E;
  localparam logic [7:0] prefix_seg_ss   = 8'h36;
  localparam logic [7:0] prefix_seg_ds   = 8'h3E;
  localparam logic [7:0] prefix_seg_fs   = 8'h64;
  localparam logic [7:0] prefix_seg_gs   = 8'h65;

  // Single opcodes with a form of their own
  localparam logic [7:0] opcode_push_imm32  = 8'h68;
  localparam logic [7:0] opcode_push_imm8   = 8'h6A;
  localparam logic [7:0] opcode_imul_imm32  = 8'h69;
  localparam logic [7:0] opcode_imul_imm8   = 8'h6B;
  localparam logic [7:0] opcode_nop         = 8'h90;
  localparam logic [7:0] opcode_mov_eax_mem = 8'hA1;

  // One decoded instruction as it leaves the decoder
  typedef struct packed {
    logic [3:0]  length;
    logic        invalid;
    opnd_form_t  opnd_form;
    logic        has_modrm;
    logic        has_sib;
    logic        has_disp;
    logic        has_imm;
    logic [7:0]  modrm;
    logic [7:0]  sib;
    logic [31:0] disp;
    logic [31:0] imm;
    logic        opsize16;
    logic        addr16;
  } decoded_insn_t;

endpackage
